//--- common/rl_trace_pkg.sv
// latency trace widths, opcode/response/class enums and the packet, launch and record structs
`default_nettype none

package rl_trace_pkg;

  // destination coordinate widths inside the mesh
  localparam int cord_x_width = 6;
  localparam int cord_y_width = 5;

  // register file addressing
  localparam int reg_id_width = 5;
  localparam int num_regs     = 32;

  // global cycle counter and latency width
  localparam int cycle_width  = 32;

  // opcode of a packet leaving the tile
  typedef enum logic [1:0] {
    op_store = 2'b00,
    op_sw    = 2'b01,
    op_load  = 2'b10,
    op_amo   = 2'b11
  } pkt_op_e;

  // type of a returning load response
  typedef enum logic [1:0] {
    ret_int    = 2'b00,
    ret_float  = 2'b01,
    ret_ifetch = 2'b10
  } ret_type_e;

  // request class, also the row index of the launch table
  typedef enum logic [1:0] {
    rc_int    = 2'b00,
    rc_float  = 2'b01,
    rc_write  = 2'b10,
    rc_icache = 2'b11
  } req_class_e;

  // fields of an outgoing packet the tracer looks at
  typedef struct packed {
    pkt_op_e                 op;
    logic [reg_id_width-1:0] reg_id;
    logic [cord_x_width-1:0] dest_x;
    logic [cord_y_width-1:0] dest_y;
    logic                    icache_fetch;
    logic                    float_wb;
  } out_pkt_s;

  // launch event, also the stored table entry
  typedef struct packed {
    req_class_e              cls;
    logic [reg_id_width-1:0] reg_id;
    logic [cycle_width-1:0]  start;
    logic [cord_x_width-1:0] dest_x;
    logic [cord_y_width-1:0] dest_y;
  } launch_s;

  // accepted load response
  typedef struct packed {
    ret_type_e               ret_type;
    logic [reg_id_width-1:0] reg_id;
  } resp_s;

  // one completed request
  typedef struct packed {
    req_class_e              cls;
    logic [cycle_width-1:0]  start;
    logic [cycle_width-1:0]  finish;
    logic [cord_x_width-1:0] dest_x;
    logic [cord_y_width-1:0] dest_y;
    logic [cycle_width-1:0]  latency;
  } lat_record_s;

endpackage

`default_nettype wire

//--- latency_trace/req_classify.sv
// req_classify: turns an outgoing packet strobe into a classified launch event
`timescale 1ns/1ps
`default_nettype none

module req_classify (
  input  wire logic                                clk_i
  , input  wire logic                              reset_i

  // packet leaving the tile
  , input  wire logic                              out_v_i
  , input  rl_trace_pkg::out_pkt_s                 out_pkt_i

  // free-running cycle counter
  , input  wire logic [rl_trace_pkg::cycle_width-1:0] cycle_i

  // launch event toward the table
  , output logic                                   launch_v_o
  , output rl_trace_pkg::launch_s                  launch_o
);

  import rl_trace_pkg::*;

  req_class_e cls;

  // priority: amo, icache fetch, float writeback, plain load, then stores
  always_comb begin
    cls = rc_write;
    case (out_pkt_i.op)
      op_amo: begin
        cls = rc_int;
      end
      op_load: begin
        if (out_pkt_i.icache_fetch) begin
          cls = rc_icache;
        end else if (out_pkt_i.float_wb) begin
          cls = rc_float;
        end else begin
          cls = rc_int;
        end
      end
      op_store, op_sw: begin
        cls = rc_write;
      end
      default: begin
        cls = rc_write;
      end
    endcase
  end

  // every outgoing packet expects a reply, so each one is a launch
  assign launch_v_o = out_v_i;

  // start cycle is sampled in the issuing cycle
  assign launch_o = '{
    cls    : cls,
    reg_id : out_pkt_i.reg_id,
    start  : cycle_i,
    dest_x : out_pkt_i.dest_x,
    dest_y : out_pkt_i.dest_y
  };

endmodule

`default_nettype wire

//--- latency_trace/launch_table.sv
// launch_table: per-class, per-register launch entries plus one icache entry, with a read port
`timescale 1ns/1ps
`default_nettype none

module launch_table (
  input  wire logic                                 clk_i
  , input  wire logic                               reset_i

  // write port from the classifier
  , input  wire logic                               launch_v_i
  , input  rl_trace_pkg::launch_s                   launch_i

  // read port from the matcher
  , input  rl_trace_pkg::req_class_e                rd_cls_i
  , input  wire logic [rl_trace_pkg::reg_id_width-1:0] rd_reg_id_i
  , output rl_trace_pkg::launch_s                   rd_entry_o
);

  import rl_trace_pkg::*;

  // rows for rc_int, rc_float and rc_write, indexed by the class code
  localparam int num_rows_lp = 3;

  launch_s [num_rows_lp-1:0][num_regs-1:0] tbl_r;

  // icache keeps only the latest fetch
  launch_s icache_r;

  logic is_icache_wr;
  logic is_icache_rd;

  assign is_icache_wr = (launch_i.cls == rc_icache);
  assign is_icache_rd = (rd_cls_i == rc_icache);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tbl_r    <= '0;
      icache_r <= '0;
    end else if (launch_v_i) begin
      if (is_icache_wr) begin
        icache_r <= launch_i;
      end else begin
        tbl_r[launch_i.cls][launch_i.reg_id] <= launch_i;
      end
    end
  end

  // read is combinational, so a same-cycle launch is not seen yet
  always_comb begin
    if (is_icache_rd) begin
      rd_entry_o = icache_r;
    end else begin
      rd_entry_o = tbl_r[rd_cls_i][rd_reg_id_i];
    end
  end

endmodule

`default_nettype wire

//--- latency_trace/resp_match.sv
// resp_match: maps responses and credits onto table entries and registers the latency record
`timescale 1ns/1ps
`default_nettype none

module resp_match (
  input  wire logic                                    clk_i
  , input  wire logic                                  reset_i

  // load response coming back
  , input  wire logic                                  resp_v_i
  , input  wire logic                                  resp_yumi_i
  , input  rl_trace_pkg::resp_s                        resp_i

  // write acknowledge
  , input  wire logic                                  credit_v_i
  , input  wire logic [rl_trace_pkg::reg_id_width-1:0] credit_reg_id_i

  , input  wire logic                                  trace_en_i
  , input  wire logic [rl_trace_pkg::cycle_width-1:0]  cycle_i

  // table lookup
  , output rl_trace_pkg::req_class_e                   rd_cls_o
  , output logic [rl_trace_pkg::reg_id_width-1:0]      rd_reg_id_o
  , input  rl_trace_pkg::launch_s                      rd_entry_i

  // latency record, one cycle after acceptance
  , output logic                                       rec_v_o
  , output rl_trace_pkg::lat_record_s                  rec_o
);

  import rl_trace_pkg::*;

  logic resp_acc;
  logic credit_only;
  logic ret_known;
  logic rec_hit;

  lat_record_s rec_n;

  assign resp_acc = resp_v_i & resp_yumi_i;

  // a credit alongside a pending response is not traced
  assign credit_only = credit_v_i & ~resp_v_i;

  // response type selects the class row, a lone credit looks up the write row
  always_comb begin
    rd_cls_o  = rc_write;
    ret_known = 1'b1;
    if (resp_acc) begin
      case (resp_i.ret_type)
        ret_int:    rd_cls_o = rc_int;
        ret_float:  rd_cls_o = rc_float;
        ret_ifetch: rd_cls_o = rc_icache;
        default: begin
          rd_cls_o  = rc_int;
          ret_known = 1'b0;
        end
      endcase
    end
  end

  assign rd_reg_id_o = resp_acc ? resp_i.reg_id : credit_reg_id_i;

  assign rec_hit = trace_en_i & ((resp_acc & ret_known) | credit_only);

  assign rec_n = '{
    cls     : rd_cls_o,
    start   : rd_entry_i.start,
    finish  : cycle_i,
    dest_x  : rd_entry_i.dest_x,
    dest_y  : rd_entry_i.dest_y,
    latency : cycle_i - rd_entry_i.start
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rec_v_o <= 1'b0;
    end else begin
      rec_v_o <= rec_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rec_hit) begin
      rec_o <= rec_n;
    end
  end

endmodule

`default_nettype wire

//--- verilog/latency_stats.sv
// latency_stats: per-class request count, latency sum and latency max with selectable readout
`timescale 1ns/1ps
`default_nettype none

module latency_stats #(
  parameter int stat_width_p = 32
) (
  input  wire logic                                   clk_i
  , input  wire logic                                 reset_i

  // incoming latency records
  , input  wire logic                                 rec_v_i
  , input  rl_trace_pkg::lat_record_s                 rec_i

  // readout
  , input  rl_trace_pkg::req_class_e                  stat_sel_i
  , output logic [stat_width_p-1:0]                   stat_count_o
  , output logic [stat_width_p-1:0]                   stat_sum_o
  , output logic [rl_trace_pkg::cycle_width-1:0]      stat_max_o
);

  import rl_trace_pkg::*;

  localparam int num_cls_lp = 4;

  // wide enough for the sum plus one carry bit
  localparam int sum_w_lp = ((stat_width_p > cycle_width) ? stat_width_p : cycle_width) + 1;

  logic [num_cls_lp-1:0][stat_width_p-1:0] count_r;
  logic [num_cls_lp-1:0][stat_width_p-1:0] sum_r;
  logic [num_cls_lp-1:0][cycle_width-1:0]  max_r;

  logic [stat_width_p-1:0] count_cur;
  logic [stat_width_p-1:0] sum_cur;
  logic [cycle_width-1:0]  max_cur;
  logic [stat_width_p-1:0] count_nxt;
  logic [stat_width_p-1:0] sum_nxt;
  logic [cycle_width-1:0]  max_nxt;
  logic [sum_w_lp-1:0]     sum_wide;
  logic [sum_w_lp-1:0]     sat_lim;

  assign count_cur = count_r[rec_i.cls];
  assign sum_cur   = sum_r[rec_i.cls];
  assign max_cur   = max_r[rec_i.cls];

  assign sat_lim  = sum_w_lp'({stat_width_p{1'b1}});
  assign sum_wide = sum_w_lp'(sum_cur) + sum_w_lp'(rec_i.latency);

  // count and sum stick at all ones
  always_comb begin
    count_nxt = (count_cur == {stat_width_p{1'b1}}) ? count_cur : count_cur + 1'b1;
    sum_nxt   = (sum_wide > sat_lim) ? {stat_width_p{1'b1}} : sum_wide[stat_width_p-1:0];
    max_nxt   = (rec_i.latency > max_cur) ? rec_i.latency : max_cur;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
      sum_r   <= '0;
      max_r   <= '0;
    end else if (rec_v_i) begin
      count_r[rec_i.cls] <= count_nxt;
      sum_r[rec_i.cls]   <= sum_nxt;
      max_r[rec_i.cls]   <= max_nxt;
    end
  end

  assign stat_count_o = count_r[stat_sel_i];
  assign stat_sum_o   = sum_r[stat_sel_i];
  assign stat_max_o   = max_r[stat_sel_i];

endmodule

`default_nettype wire

//--- verilog/rl_trace_top.sv
// rl_trace_top: request classifier, launch table, response matcher and latency statistics
`timescale 1ns/1ps
`default_nettype none

module rl_trace_top #(
  parameter int stat_width_p = 32
) (
  input  wire logic                                    clk_i
  , input  wire logic                                  reset_i

  // outgoing packets
  , input  wire logic                                  out_v_i
  , input  rl_trace_pkg::out_pkt_s                     out_pkt_i

  // load responses
  , input  wire logic                                  resp_v_i
  , input  rl_trace_pkg::resp_s                        resp_i
  , input  wire logic                                  resp_yumi_i

  // write acknowledge
  , input  wire logic                                  credit_v_i
  , input  wire logic [rl_trace_pkg::reg_id_width-1:0] credit_reg_id_i

  , input  wire logic                                  trace_en_i
  , input  wire logic [rl_trace_pkg::cycle_width-1:0]  cycle_i

  // latency records
  , output logic                                       rec_v_o
  , output rl_trace_pkg::lat_record_s                  rec_o

  // statistics readout
  , input  rl_trace_pkg::req_class_e                   stat_sel_i
  , output logic [stat_width_p-1:0]                    stat_count_o
  , output logic [stat_width_p-1:0]                    stat_sum_o
  , output logic [rl_trace_pkg::cycle_width-1:0]       stat_max_o
);

  import rl_trace_pkg::*;

  logic                    launch_v;
  launch_s                 launch;
  req_class_e              rd_cls;
  logic [reg_id_width-1:0] rd_reg_id;
  launch_s                 rd_entry;

  req_classify classify (
    .clk_i      (clk_i)
    ,.reset_i   (reset_i)
    ,.out_v_i   (out_v_i)
    ,.out_pkt_i (out_pkt_i)
    ,.cycle_i   (cycle_i)
    ,.launch_v_o(launch_v)
    ,.launch_o  (launch)
  );

  launch_table table0 (
    .clk_i       (clk_i)
    ,.reset_i    (reset_i)
    ,.launch_v_i (launch_v)
    ,.launch_i   (launch)
    ,.rd_cls_i   (rd_cls)
    ,.rd_reg_id_i(rd_reg_id)
    ,.rd_entry_o (rd_entry)
  );

  resp_match match (
    .clk_i           (clk_i)
    ,.reset_i        (reset_i)
    ,.resp_v_i       (resp_v_i)
    ,.resp_yumi_i    (resp_yumi_i)
    ,.resp_i         (resp_i)
    ,.credit_v_i     (credit_v_i)
    ,.credit_reg_id_i(credit_reg_id_i)
    ,.trace_en_i     (trace_en_i)
    ,.cycle_i        (cycle_i)
    ,.rd_cls_o       (rd_cls)
    ,.rd_reg_id_o    (rd_reg_id)
    ,.rd_entry_i     (rd_entry)
    ,.rec_v_o        (rec_v_o)
    ,.rec_o          (rec_o)
  );

  latency_stats #(
    .stat_width_p(stat_width_p)
  ) stats (
    .clk_i        (clk_i)
    ,.reset_i     (reset_i)
    ,.rec_v_i     (rec_v_o)
    ,.rec_i       (rec_o)
    ,.stat_sel_i  (stat_sel_i)
    ,.stat_count_o(stat_count_o)
    ,.stat_sum_o  (stat_sum_o)
    ,.stat_max_o  (stat_max_o)
  );

endmodule

`default_nettype wire

//--- verif/rl_trace_tb.sv
// rl_trace_top testbench with clock, reset, stimulus, reference model, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module rl_trace_tb;

  import rl_trace_pkg::*;

  localparam int clk_period_lp      = 40;
  localparam int num_tests_lp       = 6;
  localparam int max_test_cycles_lp = 700;
  localparam longint timeout_ns_lp  = 2 * num_tests_lp * max_test_cycles_lp * clk_period_lp;

  logic                    clk_i;
  logic                    reset_i;
  logic                    out_v_i;
  out_pkt_s                out_pkt_i;
  logic                    resp_v_i;
  resp_s                   resp_i;
  logic                    resp_yumi_i;
  logic                    credit_v_i;
  logic [reg_id_width-1:0] credit_reg_id_i;
  logic                    trace_en_i;
  logic [cycle_width-1:0]  cycle_i;
  logic                    rec_v_o;
  lat_record_s             rec_o;
  req_class_e              stat_sel_i;
  logic [31:0]             stat_count_o;
  logic [31:0]             stat_sum_o;
  logic [cycle_width-1:0]  stat_max_o;

  // reference model state
  launch_s     shadow_tbl [4][num_regs];
  logic        exp_v;
  lat_record_s exp_rec;
  logic [31:0] m_count [4];
  logic [31:0] m_sum [4];
  logic [31:0] m_max [4];

  int err_count;
  int check_count;
  int rec_seen;
  int rec_expected;
  int seen_mark;
  int exp_mark;
  int err_mark;
  logic [reg_id_width-1:0] r;
  logic [reg_id_width-1:0] w;
  req_class_e cls;

  rl_trace_top #(.stat_width_p(32)) UUT (
    .clk_i           (clk_i)
    ,.reset_i        (reset_i)
    ,.out_v_i        (out_v_i)
    ,.out_pkt_i      (out_pkt_i)
    ,.resp_v_i       (resp_v_i)
    ,.resp_i         (resp_i)
    ,.resp_yumi_i    (resp_yumi_i)
    ,.credit_v_i     (credit_v_i)
    ,.credit_reg_id_i(credit_reg_id_i)
    ,.trace_en_i     (trace_en_i)
    ,.cycle_i        (cycle_i)
    ,.rec_v_o        (rec_v_o)
    ,.rec_o          (rec_o)
    ,.stat_sel_i     (stat_sel_i)
    ,.stat_count_o   (stat_count_o)
    ,.stat_sum_o     (stat_sum_o)
    ,.stat_max_o     (stat_max_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  // free-running global counter
  always @(posedge clk_i) begin
    cycle_i <= cycle_i + 32'd1;
  end

  // request class by priority of amo, icache fetch, float writeback, load and store
  function automatic req_class_e expected_class(input out_pkt_s p);
    if (p.op == op_amo) return rc_int;
    if (p.op == op_load && p.icache_fetch) return rc_icache;
    if (p.op == op_load && p.float_wb) return rc_float;
    if (p.op == op_load) return rc_int;
    return rc_write;
  endfunction

  function automatic logic [31:0] sat_add(input logic [31:0] a, input logic [31:0] b);
    logic [32:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[32] ? 32'hffff_ffff : s[31:0];
  endfunction

  // model reads the table before the launch of the same edge lands in it
  always @(posedge clk_i) begin
    req_class_e rcls;
    req_class_e lcls;
    logic [reg_id_width-1:0] ridx;
    launch_s ent;
    logic hit;
    if (reset_i) begin
      exp_v <= 1'b0;
      for (int c = 0; c < 4; c++) begin
        m_count[c] <= '0;
        m_sum[c]   <= '0;
        m_max[c]   <= '0;
        for (int i = 0; i < num_regs; i++) shadow_tbl[c][i] <= '0;
      end
    end else begin
      if (exp_v) begin
        m_count[exp_rec.cls] <= sat_add(m_count[exp_rec.cls], 32'd1);
        m_sum[exp_rec.cls]   <= sat_add(m_sum[exp_rec.cls], exp_rec.latency);
        if (exp_rec.latency > m_max[exp_rec.cls]) m_max[exp_rec.cls] <= exp_rec.latency;
      end
      hit  = 1'b0;
      rcls = rc_write;
      ridx = credit_reg_id_i;
      if (resp_v_i && resp_yumi_i) begin
        hit  = 1'b1;
        ridx = resp_i.reg_id;
        case (resp_i.ret_type)
          ret_int:   rcls = rc_int;
          ret_float: rcls = rc_float;
          default:   rcls = rc_icache;
        endcase
      end else if (credit_v_i && !resp_v_i) begin
        hit = 1'b1;
      end
      hit = hit && trace_en_i;
      ent = (rcls == rc_icache) ? shadow_tbl[rc_icache][0] : shadow_tbl[rcls][ridx];
      exp_v <= hit;
      if (hit) begin
        rec_expected++;
        exp_rec <= '{cls: rcls, start: ent.start, finish: cycle_i, dest_x: ent.dest_x,
                     dest_y: ent.dest_y, latency: cycle_i - ent.start};
      end
      if (out_v_i) begin
        lcls = expected_class(out_pkt_i);
        ent  = '{cls: lcls, reg_id: out_pkt_i.reg_id, start: cycle_i,
                 dest_x: out_pkt_i.dest_x, dest_y: out_pkt_i.dest_y};
        if (lcls == rc_icache) shadow_tbl[rc_icache][0] <= ent;
        else shadow_tbl[lcls][out_pkt_i.reg_id] <= ent;
      end
    end
  end

  task automatic check_field(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    check_count++;
    assert (act_val === exp_val) else begin
      err_count++;
      $display("CHECK FAILED time %0t %s expected %0h actual %0h", $time, name, exp_val,
               act_val);
    end
  endtask

  // outputs are sampled half a cycle after the edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      check_field("rec_v_o", exp_v, rec_v_o);
      if (rec_v_o) rec_seen++;
      if (exp_v && rec_v_o) begin
        check_field("rec_o.cls", exp_rec.cls, rec_o.cls);
        check_field("rec_o.start", exp_rec.start, rec_o.start);
        check_field("rec_o.finish", exp_rec.finish, rec_o.finish);
        check_field("rec_o.dest_x", exp_rec.dest_x, rec_o.dest_x);
        check_field("rec_o.dest_y", exp_rec.dest_y, rec_o.dest_y);
        check_field("rec_o.latency", exp_rec.latency, rec_o.latency);
      end
      check_field("stat_count_o", m_count[stat_sel_i], stat_count_o);
      check_field("stat_sum_o", m_sum[stat_sel_i], stat_sum_o);
      check_field("stat_max_o", m_max[stat_sel_i], stat_max_o);
    end
  end

  task automatic tick(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic wait_gap();
    tick($urandom_range(20, 1));
  endtask

  function automatic logic [reg_id_width-1:0] rand_reg();
    return reg_id_width'($urandom_range(num_regs - 1, 0));
  endfunction

  task automatic clear_strobes();
    out_v_i     <= 1'b0;
    resp_v_i    <= 1'b0;
    resp_yumi_i <= 1'b0;
    credit_v_i  <= 1'b0;
  endtask

  function automatic out_pkt_s make_pkt(input req_class_e c, input logic [reg_id_width-1:0] id);
    out_pkt_s p;
    p = '{op: op_load, reg_id: id, dest_x: cord_x_width'($urandom_range(63, 0)),
          dest_y: cord_y_width'($urandom_range(31, 0)), icache_fetch: 1'b0, float_wb: 1'b0};
    case (c)
      rc_int: begin
        // an amo stays int whatever its float flag says
        if ($urandom_range(1, 0) == 1) begin
          p.op       = op_amo;
          p.float_wb = 1'($urandom_range(1, 0));
        end
      end
      rc_float:  p.float_wb = 1'b1;
      rc_icache: begin
        // an icache fetch outranks a float writeback
        p.icache_fetch = 1'b1;
        p.float_wb     = 1'($urandom_range(1, 0));
      end
      default: begin
        p.op           = ($urandom_range(1, 0) == 1) ? op_sw : op_store;
        p.icache_fetch = 1'($urandom_range(1, 0));
        p.float_wb     = 1'($urandom_range(1, 0));
      end
    endcase
    return p;
  endfunction

  task automatic send_launch(input req_class_e c, input logic [reg_id_width-1:0] id);
    @(posedge clk_i);
    out_v_i   <= 1'b1;
    out_pkt_i <= make_pkt(c, id);
    @(posedge clk_i);
    clear_strobes();
  endtask

  task automatic send_resp(input ret_type_e rt, input logic [reg_id_width-1:0] id,
                           input logic yumi);
    @(posedge clk_i);
    resp_v_i    <= 1'b1;
    resp_yumi_i <= yumi;
    resp_i      <= '{ret_type: rt, reg_id: id};
    @(posedge clk_i);
    clear_strobes();
  endtask

  task automatic send_credit(input logic [reg_id_width-1:0] id);
    @(posedge clk_i);
    credit_v_i      <= 1'b1;
    credit_reg_id_i <= id;
    @(posedge clk_i);
    clear_strobes();
  endtask

  task automatic finish_test(input int num, input string name);
    int seen;
    int expd;
    int errs;
    tick(3);
    seen = rec_seen - seen_mark;
    expd = rec_expected - exp_mark;
    errs = err_count - err_mark;
    assert (seen == expd) else begin
      err_count++;
      errs++;
      $display("test %0d %s: %0d records appeared where %0d were expected", num, name, seen,
               expd);
    end
    $display("test %0d %s finished: %0d records, %0d errors", num, name, seen, errs);
    seen_mark = rec_seen;
    exp_mark  = rec_expected;
    err_mark  = err_count;
  endtask

  initial begin
    #(timeout_ns_lp);
    $display("watchdog: the run did not finish within %0d ns", timeout_ns_lp);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h7b37));
    reset_i         = 1'b1;
    cycle_i         = 32'd1000;
    out_v_i         = 1'b0;
    out_pkt_i       = '0;
    resp_v_i        = 1'b0;
    resp_i          = '0;
    resp_yumi_i     = 1'b0;
    credit_v_i      = 1'b0;
    credit_reg_id_i = '0;
    trace_en_i      = 1'b1;
    stat_sel_i      = rc_int;
    err_count       = 0;
    check_count     = 0;
    rec_seen        = 0;
    rec_expected    = 0;
    seen_mark       = 0;
    exp_mark        = 0;
    err_mark        = 0;
    tick(4);
    reset_i <= 1'b0;

    // int loads and atomics
    repeat (8) begin
      r = rand_reg();
      send_launch(rc_int, r);
      wait_gap();
      send_resp(ret_int, r, 1'b1);
      wait_gap();
    end
    finish_test(1, "int_loads");

    // float and int entries on one register id
    stat_sel_i <= rc_float;
    repeat (4) begin
      r = rand_reg();
      send_launch(rc_int, r);
      wait_gap();
      send_launch(rc_float, r);
      wait_gap();
      send_resp(ret_float, r, 1'b1);
      wait_gap();
      send_resp(ret_int, r, 1'b1);
    end
    finish_test(2, "float_vs_int");

    // second fetch overwrites the single icache entry
    stat_sel_i <= rc_icache;
    send_launch(rc_icache, rand_reg());
    wait_gap();
    send_launch(rc_icache, rand_reg());
    wait_gap();
    send_resp(ret_ifetch, rand_reg(), 1'b1);
    finish_test(3, "icache_overwrite");

    // credits, credit beside a response, held back response, same-cycle launch
    stat_sel_i <= rc_write;
    repeat (3) begin
      w = rand_reg();
      send_launch(rc_write, w);
      wait_gap();
      send_credit(w);
    end
    r = rand_reg();
    w = rand_reg();
    send_launch(rc_int, r);
    send_launch(rc_write, w);
    wait_gap();
    @(posedge clk_i);
    resp_v_i        <= 1'b1;
    resp_yumi_i     <= 1'b1;
    resp_i          <= '{ret_type: ret_int, reg_id: r};
    credit_v_i      <= 1'b1;
    credit_reg_id_i <= w;
    @(posedge clk_i);
    resp_yumi_i <= 1'b0;
    @(posedge clk_i);
    clear_strobes();
    send_resp(ret_int, r, 1'b0);
    @(posedge clk_i);
    out_v_i     <= 1'b1;
    out_pkt_i   <= make_pkt(rc_int, r);
    resp_v_i    <= 1'b1;
    resp_yumi_i <= 1'b1;
    resp_i      <= '{ret_type: ret_int, reg_id: r};
    @(posedge clk_i);
    clear_strobes();
    wait_gap();
    send_resp(ret_int, r, 1'b1);
    finish_test(4, "credits_and_yumi");

    // tracing off keeps launches but drops records and stats
    stat_sel_i <= rc_int;
    @(posedge clk_i);
    trace_en_i <= 1'b0;
    r = rand_reg();
    send_launch(rc_float, r);
    wait_gap();
    send_launch(rc_int, r);
    wait_gap();
    send_resp(ret_int, r, 1'b1);
    send_credit(r);
    wait_gap();
    @(posedge clk_i);
    trace_en_i <= 1'b1;
    wait_gap();
    send_resp(ret_float, r, 1'b1);
    finish_test(5, "trace_disabled");

    // random mix, then every stat selection two cycles after the last response
    repeat (14) begin
      cls = req_class_e'($urandom_range(3, 0));
      r   = rand_reg();
      send_launch(cls, r);
      wait_gap();
      case (cls)
        rc_int:    send_resp(ret_int, r, 1'b1);
        rc_float:  send_resp(ret_float, r, 1'b1);
        rc_icache: send_resp(ret_ifetch, r, 1'b1);
        default:   send_credit(r);
      endcase
      wait_gap();
    end
    tick(1);
    for (int s = 0; s < 4; s++) begin
      stat_sel_i <= req_class_e'(s);
      @(negedge clk_i);
      check_field("stat_count_o", m_count[s], stat_count_o);
      check_field("stat_sum_o", m_sum[s], stat_sum_o);
      check_field("stat_max_o", m_max[s], stat_max_o);
      @(posedge clk_i);
    end
    finish_test(6, "random_mix_stats");

    $display("tests %0d, checks %0d, errors %0d", num_tests_lp, check_count, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
common/rl_trace_pkg.sv
latency_trace/req_classify.sv
latency_trace/launch_table.sv
latency_trace/resp_match.sv
verilog/latency_stats.sv
verilog/rl_trace_top.sv
verif/rl_trace_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the latency trace testbench with Verilator, run it, and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f flist.f \
  --top-module rl_trace_tb \
  -o rl_trace_sim

./obj_dir/rl_trace_sim > sim.log 2>&1
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
else
  echo "simulation did not report a pass"
  exit 1
fi
